//--- hdl/panel_cfg.svh
// panel geometry and command byte layout for the LED panel controller
// include wherever sizes or field widths are needed
`ifndef PANEL_CFG_SVH
`define PANEL_CFG_SVH

`define PANEL_COLUMNS 128
`define PANEL_ROWS    32

`define COLUMN_BITS   7
`define ROW_BITS      5

`define COLUMN_BYTES  1 // bytes per column field, msb first
`define PIXEL_BYTES   2 // colour bytes, msb first

`define FB_ADDR_BITS  (`ROW_BITS + `COLUMN_BITS) // row above column

`endif

//--- hdl/panel_pkg.sv
// shared Wishbone, fill command and pixel types for the panel controller
`default_nettype none
`include "panel_cfg.svh"

package panel_pkg;

    typedef struct packed {
        logic                        cyc;
        logic                        stb;
        logic                        we;
        logic [`FB_ADDR_BITS-1:0]    adr;
        logic [`PIXEL_BYTES*8-1:0]   dat_w;
    } wb_req_t;

    typedef struct packed {
        logic                        ack;
        logic [`PIXEL_BYTES*8-1:0]   dat_r;
    } wb_rsp_t;

    typedef struct packed {
        logic [`COLUMN_BITS-1:0]     x1;
        logic [`ROW_BITS-1:0]        y1;
        logic [`COLUMN_BITS-1:0]     width;
        logic [`ROW_BITS-1:0]        height;
        logic [`PIXEL_BYTES*8-1:0]   colour;
    } fill_rect_t;

    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    typedef union packed {
        logic [`PIXEL_BYTES*8-1:0]   raw;
        rgb565_t                     rgb;
    } pixel_word_u;

    typedef struct packed {
        logic [`ROW_BITS-1:0]        row;
        logic [`COLUMN_BITS-1:0]     column;
        rgb565_t                     colour;
    } scan_pixel_t;

endpackage

`default_nettype wire

//--- hdl/fill_area_walker.sv
// walks the clipped rectangle row by row and writes the colour into the framebuffer
// with one Wishbone write per access and cyc released between accesses
`timescale 1ns/1ps
`default_nettype none
`include "panel_cfg.svh"

module fill_area_walker
    import panel_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       start,
    input  wire fill_rect_t rect,
    output wb_req_t         wb_req,
    input  wire wb_rsp_t    wb_rsp,
    output logic            done
);

    logic [`COLUMN_BITS:0]      x_end; // one bit wider than a column
    logic [`ROW_BITS:0]         y_end;
    logic [`COLUMN_BITS-1:0]    x_clip;
    logic [`ROW_BITS-1:0]       y_clip;
    logic                       empty;
    logic [`COLUMN_BITS-1:0]    x_first;
    logic [`COLUMN_BITS-1:0]    x_last;
    logic [`ROW_BITS-1:0]       y_last;
    logic [`COLUMN_BITS-1:0]    col;
    logic [`ROW_BITS-1:0]       row;
    logic [`PIXEL_BYTES*8-1:0]  colour;
    logic                       busy;
    logic                       cyc;
    logic                       last_pixel;

    assign x_end  = {1'b0, rect.x1} + {1'b0, rect.width};
    assign y_end  = {1'b0, rect.y1} + {1'b0, rect.height};
    assign x_clip = (x_end > `PANEL_COLUMNS) ? `COLUMN_BITS'(`PANEL_COLUMNS - 1)
                                             : `COLUMN_BITS'(x_end - 1'b1);
    assign y_clip = (y_end > `PANEL_ROWS) ? `ROW_BITS'(`PANEL_ROWS - 1)
                                          : `ROW_BITS'(y_end - 1'b1);
    assign empty  = (rect.width == '0) || (rect.height == '0);

    assign last_pixel = (col == x_last) && (row == y_last);

    assign wb_req.cyc   = cyc;
    assign wb_req.stb   = cyc;
    assign wb_req.we    = 1'b1;
    assign wb_req.adr   = {row, col};
    assign wb_req.dat_w = colour;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            cyc  <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= !empty;
                cyc  <= !empty;
                done <= empty; // zero area still reports done
            end else if (cyc && wb_rsp.ack) begin
                cyc <= 1'b0; // give the other master a turn
                if (last_pixel) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end else if (busy) begin
                cyc <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            x_first <= rect.x1;
            x_last  <= x_clip;
            y_last  <= y_clip;
            col     <= rect.x1;
            row     <= rect.y1;
            colour  <= rect.colour;
        end else if (cyc && wb_rsp.ack && !last_pixel) begin
            if (col == x_last) begin
                col <= x_first; // next row
                row <= row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // writes stay inside the clipped rectangle
    assert property (@(posedge clk) disable iff (reset)
        wb_req.stb |-> (col <= x_last) && (row <= y_last));

    assert property (@(posedge clk) disable iff (reset)
        (wb_req.stb && !wb_rsp.ack) |=> $stable(wb_req));

endmodule

`default_nettype wire

//--- hdl/cmd_fillrect.sv
// fill-rectangle command stage: gathers the field bytes from the host stream,
// then runs the area walker and reports done
`timescale 1ns/1ps
`default_nettype none
`include "panel_cfg.svh"

module cmd_fillrect
    import panel_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic [7:0] data,
    input  wire logic       data_valid,
    output logic            cmd_ready,
    output logic            done,
    output wb_req_t         wb_req,
    input  wire wb_rsp_t    wb_rsp
);

    localparam int COL_CNT_BITS = (`COLUMN_BYTES > 1) ? $clog2(`COLUMN_BYTES) : 1;
    localparam int PIX_CNT_BITS = (`PIXEL_BYTES > 1) ? $clog2(`PIXEL_BYTES) : 1;

    localparam logic [2:0] S_X1     = 3'd0;
    localparam logic [2:0] S_Y1     = 3'd1;
    localparam logic [2:0] S_WIDTH  = 3'd2;
    localparam logic [2:0] S_HEIGHT = 3'd3;
    localparam logic [2:0] S_COLOUR = 3'd4;
    localparam logic [2:0] S_START  = 3'd5;
    localparam logic [2:0] S_RUN    = 3'd6;
    localparam logic [2:0] S_DONE   = 3'd7;

    logic [2:0]                 state;
    logic [`COLUMN_BYTES*8-1:0] x1_bytes;
    logic [`COLUMN_BYTES*8-1:0] width_bytes;
    logic [`ROW_BITS-1:0]       y1;
    logic [`ROW_BITS-1:0]       height;
    logic [`PIXEL_BYTES*8-1:0]  colour;
    logic [COL_CNT_BITS-1:0]    col_cnt; // column bytes still to come
    logic [PIX_CNT_BITS-1:0]    pix_cnt; // colour bytes still to come
    logic                       take;
    logic                       fill_start;
    logic                       fill_done;
    fill_rect_t                 rect;

    assign take       = data_valid && cmd_ready;
    assign fill_start = (state == S_START);
    assign done       = (state == S_DONE);

    assign rect.x1     = x1_bytes[`COLUMN_BITS-1:0]; // upper bits dropped
    assign rect.y1     = y1;
    assign rect.width  = width_bytes[`COLUMN_BITS-1:0];
    assign rect.height = height;
    assign rect.colour = colour;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= S_X1;
            cmd_ready <= 1'b1;
            col_cnt   <= COL_CNT_BITS'(`COLUMN_BYTES - 1);
            pix_cnt   <= PIX_CNT_BITS'(`PIXEL_BYTES - 1);
        end else begin
            case (state)
                S_X1: begin
                    if (take) begin
                        if (col_cnt == '0) begin
                            state   <= S_Y1;
                            col_cnt <= COL_CNT_BITS'(`COLUMN_BYTES - 1); // reload for width
                        end else begin
                            col_cnt <= col_cnt - 1'b1;
                        end
                    end
                end
                S_Y1: begin
                    if (take) begin
                        state <= S_WIDTH;
                    end
                end
                S_WIDTH: begin
                    if (take) begin
                        if (col_cnt == '0) begin
                            state <= S_HEIGHT;
                        end else begin
                            col_cnt <= col_cnt - 1'b1;
                        end
                    end
                end
                S_HEIGHT: begin
                    if (take) begin
                        state <= S_COLOUR;
                    end
                end
                S_COLOUR: begin
                    if (take) begin
                        if (pix_cnt == '0) begin
                            state     <= S_START;
                            cmd_ready <= 1'b0; // same edge as last byte
                        end else begin
                            pix_cnt <= pix_cnt - 1'b1;
                        end
                    end
                end
                S_START: begin
                    state <= S_RUN;
                end
                S_RUN: begin
                    if (fill_done) begin
                        state <= S_DONE;
                    end
                end
                S_DONE: begin
                    state     <= S_X1;
                    cmd_ready <= 1'b1;
                    col_cnt   <= COL_CNT_BITS'(`COLUMN_BYTES - 1);
                    pix_cnt   <= PIX_CNT_BITS'(`PIXEL_BYTES - 1);
                end
                default: state <= S_X1;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_DONE) begin
            x1_bytes    <= '0;
            width_bytes <= '0;
            y1          <= '0;
            height      <= '0;
            colour      <= '0;
        end else if (take) begin
            case (state)
                S_X1:     x1_bytes[col_cnt*8 +: 8] <= data;
                S_Y1:     y1 <= data[`ROW_BITS-1:0];
                S_WIDTH:  width_bytes[col_cnt*8 +: 8] <= data;
                S_HEIGHT: height <= data[`ROW_BITS-1:0];
                S_COLOUR: colour[pix_cnt*8 +: 8] <= data;
                default:  ;
            endcase
        end
    end

    fill_area_walker u_fill_area_walker (
        .clk    (clk),
        .reset  (reset),
        .start  (fill_start),
        .rect   (rect),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .done   (fill_done)
    );

endmodule

`default_nettype wire

//--- hdl/fb_arbiter.sv
// round-robin arbiter that shares the framebuffer port between the fill walker (m0)
// and the scan reader (m1); the grant moves only while the owner has cyc low
`timescale 1ns/1ps
`default_nettype none

module fb_arbiter
    import panel_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire wb_req_t m0_req,
    input  wire wb_req_t m1_req,
    output wb_rsp_t      m0_rsp,
    output wb_rsp_t      m1_rsp,
    output wb_req_t      s_req,
    input  wire wb_rsp_t s_rsp
);

    logic grant; // 0 fill, 1 scan
    logic granted_cyc;
    logic other_cyc;

    assign granted_cyc = grant ? m1_req.cyc : m0_req.cyc;
    assign other_cyc   = grant ? m0_req.cyc : m1_req.cyc;

    // owner idle and the other side waiting, so hand over
    always_ff @(posedge clk) begin
        if (reset) begin
            grant <= 1'b0;
        end else if (!granted_cyc && other_cyc) begin
            grant <= !grant;
        end
    end

    assign s_req = grant ? m1_req : m0_req;

    assign m0_rsp.ack   = s_rsp.ack && !grant;
    assign m0_rsp.dat_r = s_rsp.dat_r;
    assign m1_rsp.ack   = s_rsp.ack && grant;
    assign m1_rsp.dat_r = s_rsp.dat_r;

    // an access in flight must finish on the master that started it
    assert property (@(posedge clk) disable iff (reset) s_rsp.ack |-> granted_cyc);

endmodule

`default_nettype wire

//--- hdl/framebuffer_ram.sv
// single-port framebuffer behind a Wishbone classic slave holding one word per pixel
// that clears itself after reset before answering any access
`timescale 1ns/1ps
`default_nettype none
`include "panel_cfg.svh"

module framebuffer_ram
    import panel_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire wb_req_t wb_req,
    output wb_rsp_t      wb_rsp
);

    localparam int DEPTH = `PANEL_COLUMNS * `PANEL_ROWS;

    logic [`PIXEL_BYTES*8-1:0] mem [DEPTH];
    logic [`PIXEL_BYTES*8-1:0] rd_data;
    logic [`FB_ADDR_BITS-1:0]  clear_addr;
    logic                      clearing;
    logic                      ack;
    logic                      access;

    assign access = wb_req.cyc && wb_req.stb && !ack && !clearing;

    always_ff @(posedge clk) begin
        if (reset) begin
            clearing   <= 1'b1;
            clear_addr <= '0;
            ack        <= 1'b0;
        end else begin
            ack <= access; // single cycle and never back to back
            if (clearing) begin
                clear_addr <= clear_addr + 1'b1;
                if (clear_addr == `FB_ADDR_BITS'(DEPTH - 1)) begin
                    clearing <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clearing) begin
            mem[clear_addr] <= '0;
        end else if (access && wb_req.we) begin
            mem[wb_req.adr] <= wb_req.dat_w;
        end
        if (access) begin
            rd_data <= mem[wb_req.adr];
        end
    end

    assign wb_rsp.ack   = ack;
    assign wb_rsp.dat_r = rd_data;

    // master holds the same address until it sees ack
    assert property (@(posedge clk) disable iff (reset)
        ack |-> wb_req.stb && $stable(wb_req.adr));

endmodule

`default_nettype wire

//--- hdl/scan_reader.sv
// endless raster read of the framebuffer for panel refresh; each read ack
// becomes one decoded pixel beat with its row and column
`timescale 1ns/1ps
`default_nettype none
`include "panel_cfg.svh"

module scan_reader
    import panel_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,
    output wb_req_t      wb_req,
    input  wire wb_rsp_t wb_rsp,
    output scan_pixel_t  pixel,
    output logic         pixel_valid,
    output logic         frame_start
);

    logic [`FB_ADDR_BITS-1:0] addr;
    logic                     cyc;
    pixel_word_u              word;

    // one read at a time, cyc dropped for a cycle after each ack
    always_ff @(posedge clk) begin
        if (reset) begin
            cyc  <= 1'b0;
            addr <= '0;
        end else if (cyc && wb_rsp.ack) begin
            cyc  <= 1'b0;
            addr <= addr + 1'b1; // wraps at end of frame
        end else begin
            cyc <= 1'b1;
        end
    end

    assign wb_req.cyc   = cyc;
    assign wb_req.stb   = cyc;
    assign wb_req.we    = 1'b0;
    assign wb_req.adr   = addr;
    assign wb_req.dat_w = '0;

    assign word.raw = wb_rsp.dat_r;

    assign pixel.row    = addr[`FB_ADDR_BITS-1 -: `ROW_BITS];
    assign pixel.column = addr[`COLUMN_BITS-1:0];
    assign pixel.colour = word.rgb;

    assign pixel_valid = cyc && wb_rsp.ack;
    assign frame_start = pixel_valid && (addr == '0);

endmodule

`default_nettype wire

//--- hdl/panel_ctrl_top.sv
// top level of the panel core: command/fill path and refresh scan sharing
// one framebuffer through the arbiter
`timescale 1ns/1ps
`default_nettype none

module panel_ctrl_top
    import panel_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic [7:0] data,
    input  wire logic       data_valid,
    output logic            cmd_ready,
    output logic            done,
    output scan_pixel_t     pixel,
    output logic            pixel_valid,
    output logic            frame_start
);

    wb_req_t fill_req;
    wb_rsp_t fill_rsp;
    wb_req_t scan_req;
    wb_rsp_t scan_rsp;
    wb_req_t fb_req;
    wb_rsp_t fb_rsp;

    cmd_fillrect u_cmd_fillrect (
        .clk        (clk),
        .reset      (reset),
        .data       (data),
        .data_valid (data_valid),
        .cmd_ready  (cmd_ready),
        .done       (done),
        .wb_req     (fill_req),
        .wb_rsp     (fill_rsp)
    );

    fb_arbiter u_fb_arbiter (
        .clk    (clk),
        .reset  (reset),
        .m0_req (fill_req), // master 0 fill
        .m1_req (scan_req),
        .m0_rsp (fill_rsp),
        .m1_rsp (scan_rsp),
        .s_req  (fb_req),
        .s_rsp  (fb_rsp)
    );

    framebuffer_ram u_framebuffer_ram (
        .clk    (clk),
        .reset  (reset),
        .wb_req (fb_req),
        .wb_rsp (fb_rsp)
    );

    scan_reader u_scan_reader (
        .clk         (clk),
        .reset       (reset),
        .wb_req      (scan_req),
        .wb_rsp      (scan_rsp),
        .pixel       (pixel),
        .pixel_valid (pixel_valid),
        .frame_start (frame_start)
    );

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
// clock and reset source for the panel controller testbench
// 4 ns clock, reset held high for the first 5 rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0; // released just after the fifth edge
    end

endmodule

`default_nettype wire

//--- bench/panel_ctrl_tb.sv
// directed testbench for the panel controller core that sends fill commands over the byte
// stream and checks every refreshed frame against a reference framebuffer
`timescale 1ns/1ps
`default_nettype none
`include "panel_cfg.svh"

module panel_ctrl_tb
    import panel_pkg::*;
();

    localparam int COLS       = `PANEL_COLUMNS;
    localparam int DEPTH      = `PANEL_COLUMNS * `PANEL_ROWS;
    localparam int PW         = `PIXEL_BYTES * 8;
    localparam int FRAME_WAIT = 60000; // sweep plus a busy frame
    localparam int BEAT_WAIT  = 100;
    localparam int CMD_WAIT   = 100000;

    logic        clk;
    logic        reset;
    logic [7:0]  data;
    logic        data_valid;
    logic        cmd_ready;
    logic        done;
    scan_pixel_t pixel;
    logic        pixel_valid;
    logic        frame_start;

    logic [PW-1:0] model [DEPTH]; // expected framebuffer
    logic [31:0]   lfsr_state;

    tb_clock u_tb_clock (
        .clk   (clk),
        .reset (reset)
    );

    panel_ctrl_top u_panel_ctrl_top (
        .clk         (clk),
        .reset       (reset),
        .data        (data),
        .data_valid  (data_valid),
        .cmd_ready   (cmd_ready),
        .done        (done),
        .pixel       (pixel),
        .pixel_valid (pixel_valid),
        .frame_start (frame_start)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha3000000) : (s >> 1); // galois form shifting right
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic stop_on_failure;
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR: %s = 0x%0h, expected 0x%0h", name, actual, expected);
            stop_on_failure();
        end
    endtask

    task automatic timeout_failure(input string what);
        $display("timed out waiting for %s", what);
        stop_on_failure();
    endtask

    task automatic wait_reset_release;
        int waited;
        waited = 0;
        @(negedge clk);
        while (reset) begin
            waited++;
            if (waited > 20) timeout_failure("reset release");
            @(negedge clk);
        end
    endtask

    // the posedge at the top takes the byte offered by the previous call
    task automatic send_byte(input logic [7:0] value);
        int waited;
        @(posedge clk);
        #1;
        data       = value;
        data_valid = 1'b1;
        waited     = 0;
        @(negedge clk);
        while (!cmd_ready) begin
            waited++;
            if (waited > CMD_WAIT) timeout_failure("cmd_ready");
            @(negedge clk);
        end
    endtask

    task automatic model_fill(input int x_raw, input int y_raw, input int w_raw,
                              input int h_raw, input logic [PW-1:0] colour);
        int x1;
        int y1;
        int x_last;
        int y_last;
        x1     = x_raw & (COLS - 1);
        y1     = y_raw & (`PANEL_ROWS - 1);
        x_last = x1 + (w_raw & (COLS - 1)) - 1;
        y_last = y1 + (h_raw & (`PANEL_ROWS - 1)) - 1;
        if (x_last > COLS - 1) x_last = COLS - 1;
        if (y_last > `PANEL_ROWS - 1) y_last = `PANEL_ROWS - 1;
        for (int r = y1; r <= y_last; r++) begin
            for (int c = x1; c <= x_last; c++) begin
                model[r * COLS + c] = colour;
            end
        end
    endtask

    // junk keeps data_valid high with a stray byte while cmd_ready is low
    task automatic send_fill(input logic [`COLUMN_BYTES*8-1:0] x, input logic [7:0] y,
                             input logic [`COLUMN_BYTES*8-1:0] w, input logic [7:0] h,
                             input logic [PW-1:0] colour, input bit junk);
        int waited;
        for (int i = `COLUMN_BYTES - 1; i >= 0; i--) send_byte(x[i*8 +: 8]);
        send_byte(y);
        for (int i = `COLUMN_BYTES - 1; i >= 0; i--) send_byte(w[i*8 +: 8]);
        send_byte(h);
        for (int i = `PIXEL_BYTES - 1; i >= 0; i--) send_byte(colour[i*8 +: 8]);
        @(posedge clk);
        #1;
        if (junk) data = 8'h5a;
        else data_valid = 1'b0;
        waited = 0;
        @(negedge clk);
        while (!done) begin
            check_value("cmd_ready", cmd_ready, 1'b0);
            waited++;
            if (waited > CMD_WAIT) timeout_failure("done");
            @(negedge clk);
        end
        if (junk) begin
            @(posedge clk);
            #1;
            data_valid = 1'b0;
        end
        @(negedge clk);
        check_value("done", done, 1'b0); // single cycle pulse
        check_value("cmd_ready", cmd_ready, 1'b1);
        model_fill(x, y, w, h, colour);
    endtask

    task automatic wait_pixel;
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            check_value("done", done, 1'b0);
            waited++;
            if (waited > BEAT_WAIT) timeout_failure("pixel_valid");
        end while (!pixel_valid);
    endtask

    task automatic compare_frame;
        int            waited;
        string         at;
        logic [PW-1:0] expected;
        waited = 0;
        @(negedge clk);
        while (!frame_start) begin
            waited++;
            if (waited > FRAME_WAIT) timeout_failure("frame_start");
            @(negedge clk);
        end
        for (int beat = 0; beat < DEPTH; beat++) begin
            if (beat != 0) begin
                wait_pixel();
                check_value("frame_start", frame_start, 1'b0);
            end
            expected = model[beat];
            at       = $sformatf(" at row %0d col %0d", beat / COLS, beat % COLS);
            check_value("pixel.row", pixel.row, beat / COLS);
            check_value("pixel.column", pixel.column, beat % COLS);
            check_value({"pixel.colour.r", at}, pixel.colour.r, expected[15:11]);
            check_value({"pixel.colour.g", at}, pixel.colour.g, expected[10:5]);
            check_value({"pixel.colour.b", at}, pixel.colour.b, expected[4:0]);
        end
    endtask

    task automatic test_reset_state;
        check_value("cmd_ready", cmd_ready, 1'b1);
        check_value("done", done, 1'b0);
        check_value("pixel_valid", pixel_valid, 1'b0); // still clearing
        compare_frame();
    endtask

    task automatic test_single_rect;
        send_fill(8'd10, 8'd4, 8'd20, 8'd8, 16'hab5c, 1'b0);
        compare_frame();
    endtask

    // upper bits of x and y set with both edges crossed
    task automatic test_clipped_rect;
        send_fill(8'hf8, 8'hfc, 8'd30, 8'd10, 16'h07e0, 1'b0);
        compare_frame();
    endtask

    task automatic test_zero_area;
        send_fill(8'd30, 8'd10, 8'd0, 8'd5, 16'hffff, 1'b0);
        send_fill(8'd30, 8'd10, 8'd5, 8'd0, 16'hffff, 1'b0);
        compare_frame();
    endtask

    task automatic test_overlap;
        send_fill(8'd40, 8'd2, 8'd30, 8'd12, 16'h001f, 1'b1);
        send_fill(8'd55, 8'd8, 8'd30, 8'd12, 16'hf800, 1'b0);
        compare_frame();
    endtask

    task automatic test_random_fills;
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] w;
        logic [31:0] h;
        logic [31:0] colour;
        for (int n = 0; n < 8; n++) begin
            draw_bits(`COLUMN_BYTES * 8, x);
            draw_bits(8, y);
            draw_bits(`COLUMN_BYTES * 8, w);
            draw_bits(8, h);
            draw_bits(PW, colour);
            send_fill(x[`COLUMN_BYTES*8-1:0], y[7:0], w[`COLUMN_BYTES*8-1:0], h[7:0],
                      colour[PW-1:0], 1'b0);
            compare_frame();
        end
    endtask

    initial begin
        data       = '0;
        data_valid = 1'b0;
        lfsr_state = 32'hd610c813;
        for (int i = 0; i < DEPTH; i++) model[i] = '0;
        wait_reset_release();
        test_reset_state();
        test_single_rect();
        test_clipped_rect();
        test_zero_area();
        test_overlap();
        test_random_fills();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+hdl
hdl/panel_pkg.sv
hdl/fill_area_walker.sv
hdl/cmd_fillrect.sv
hdl/fb_arbiter.sv
hdl/framebuffer_ram.sv
hdl/scan_reader.sv
hdl/panel_ctrl_top.sv
bench/tb_clock.sv
bench/panel_ctrl_tb.sv

//--- Bender.yml
package:
  name: panel_ctrl

export_include_dirs:
  - hdl

sources:
  - target: rtl
    files:
      - hdl/panel_pkg.sv
      - hdl/fill_area_walker.sv
      - hdl/cmd_fillrect.sv
      - hdl/fb_arbiter.sv
      - hdl/framebuffer_ram.sv
      - hdl/scan_reader.sv
      - hdl/panel_ctrl_top.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/panel_ctrl_tb.sv
